//--- design/slapfight_video_macros.svh
`ifndef SLAPFIGHT_VIDEO_MACROS_SVH
`define SLAPFIGHT_VIDEO_MACROS_SVH

// ============================================================
// raster geometry, one pixel per pixel_clk
// ============================================================
`define SV_H_TOTAL         384 // pixels per line
`define SV_H_ACTIVE        256 // visible pixels
`define SV_H_SYNC_START    304
`define SV_H_SYNC_END      336 // 32 clocks of hsync

`define SV_V_TOTAL         264 // lines per frame
`define SV_V_ACTIVE_START  16
`define SV_V_ACTIVE_END    240 // 224 visible lines
`define SV_V_SYNC_START    248
`define SV_V_SYNC_END      251 // 3 lines of vsync

// ============================================================
// widths
// ============================================================
`define SV_HPOS_W          9
`define SV_VPOS_W          8
`define SV_VCNT_W          9  // line counter needs 9 bits for 264 lines
`define SV_COLOR_W         8
`define SV_RGB_CH_W        4
`define SV_HOST_ADDR_W     9
`define SV_HOST_DATA_W     12
`define SV_PIPE_LAT        2  // codes in to rgb out, in edges

// host address map
`define SV_ADDR_HSCRL_LO   0
`define SV_ADDR_HSCRL_HI   1
`define SV_ADDR_VSCRL      2
`define SV_ADDR_PAL_BASE   256 // 256..511 are palette entries

`endif

//--- design/slapfight_video_pkg.sv
`default_nettype none

`include "slapfight_video_macros.svh"

package slapfight_video_pkg;

	// one pixel code word, read two ways by the mixer
	typedef union packed {
		struct packed {
			logic [5:0] bank; // fg colour bank
			logic [1:0] pen;  // zero is transparent
		} fg;
		struct packed {
			logic [3:0] bank; // sprite colour bank
			logic [3:0] pen;  // zero is transparent
		} sp;
	} color_code_u;

	typedef struct packed {
		logic [`SV_RGB_CH_W-1:0] red;
		logic [`SV_RGB_CH_W-1:0] green;
		logic [`SV_RGB_CH_W-1:0] blue;
	} rgb_t;

	// scroll select, same outputs as the 2-to-4 decoder on the board
	typedef enum logic [1:0] {
		SEL_HSCRL_LO = 2'd0,
		SEL_HSCRL_HI = 2'd1,
		SEL_VSCRL    = 2'd2,
		SEL_NONE     = 2'd3  // mcu port slot, unused here
	} reg_sel_e;

endpackage

`default_nettype wire

//--- design/raster_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "slapfight_video_macros.svh"

// raster position and blanking from the timing generator
interface raster_if;

	logic [`SV_HPOS_W-1:0] h_pos; // displayed column, flip applied
	logic [`SV_VPOS_W-1:0] v_pos; // displayed line, flip applied
	logic                  h_blank;
	logic                  v_blank;
	logic                  flip;  // screen flip, fixed since reset

	modport timing_mp (
		output h_pos, v_pos, h_blank, v_blank, flip
	);

	modport scroll_mp (
		input h_pos, v_pos, flip
	);

	modport mix_mp (
		input h_blank, v_blank
	);

endinterface

`default_nettype wire

//--- design/video_timing_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "slapfight_video_macros.svh"

module video_timing_gen (
	input  wire        pixel_clk,
	input  wire        RESET_n,
	input  wire        flip_i,   // screen flip, only looked at during reset
	raster_if.timing_mp raster,
	output logic       h_sync_o,
	output logic       v_sync_o,
	output logic       blank_o
);

	localparam logic [`SV_HPOS_W-1:0] H_LAST = `SV_H_TOTAL - 1;
	localparam logic [`SV_VCNT_W-1:0] V_LAST = `SV_V_TOTAL - 1;

	logic [`SV_HPOS_W-1:0]   h_cnt;
	logic [`SV_VCNT_W-1:0]   v_cnt;
	logic                    flip_q;
	logic                    h_wrap;
	logic                    h_sync_raw;
	logic                    v_sync_raw;
	logic                    blank_raw;
	logic [`SV_PIPE_LAT-1:0] hs_dly;
	logic [`SV_PIPE_LAT-1:0] vs_dly;
	logic [`SV_PIPE_LAT-1:0] bl_dly;

	// ============================================================
	// counters, the sync proms become compares
	// ============================================================
	assign h_wrap = (h_cnt == H_LAST);

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_wrap) begin
			h_cnt <= '0;
			v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1; // line clock
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// flip latched while reset held, then frozen
	always_ff @(posedge pixel_clk) begin
		if (!RESET_n)
			flip_q <= flip_i;
	end

	// flipped screen counts down, i.e. inverted count
	assign raster.h_pos   = h_cnt ^ {`SV_HPOS_W{flip_q}};
	assign raster.v_pos   = v_cnt[`SV_VPOS_W-1:0] ^ {`SV_VPOS_W{flip_q}};
	assign raster.flip    = flip_q;
	assign raster.h_blank = (h_cnt >= `SV_H_ACTIVE);
	assign raster.v_blank = (v_cnt < `SV_V_ACTIVE_START) || (v_cnt >= `SV_V_ACTIVE_END);

	assign h_sync_raw = (h_cnt >= `SV_H_SYNC_START) && (h_cnt < `SV_H_SYNC_END);
	assign v_sync_raw = (v_cnt >= `SV_V_SYNC_START) && (v_cnt < `SV_V_SYNC_END);
	assign blank_raw  = raster.h_blank | raster.v_blank;

	// ============================================================
	// delay to line up with the mixer and palette stages
	// ============================================================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			hs_dly <= '0;
			vs_dly <= '0;
			bl_dly <= '1; // blanked out of reset
		end else begin
			hs_dly <= {hs_dly[`SV_PIPE_LAT-2:0], h_sync_raw};
			vs_dly <= {vs_dly[`SV_PIPE_LAT-2:0], v_sync_raw};
			bl_dly <= {bl_dly[`SV_PIPE_LAT-2:0], blank_raw};
		end
	end

	assign h_sync_o = hs_dly[`SV_PIPE_LAT-1];
	assign v_sync_o = vs_dly[`SV_PIPE_LAT-1];
	assign blank_o  = bl_dly[`SV_PIPE_LAT-1];

	a_hcnt_range: assert property (
		@(posedge pixel_clk) disable iff (!RESET_n) h_cnt < `SV_H_TOTAL
	);

endmodule

`default_nettype wire

//--- design/scroll_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "slapfight_video_macros.svh"

module scroll_regs import slapfight_video_pkg::*; (
	input  wire                        pixel_clk,
	input  wire                        RESET_n,
	input  wire                        host_wr_i,
	input  wire [`SV_HOST_ADDR_W-1:0]  host_addr_i,
	input  wire [`SV_HOST_DATA_W-1:0]  host_data_i,
	output logic [`SV_HPOS_W-1:0]      h_scroll_o,
	output logic [`SV_VPOS_W-1:0]      v_scroll_o,
	output logic                       pal_we_o,
	output logic [`SV_COLOR_W-1:0]     pal_idx_o,
	output rgb_t                       pal_data_o
);

	reg_sel_e sel;
	logic     scroll_wr;

	// low half of the map, like the board's 2-to-4 decode
	always_comb begin
		sel = SEL_NONE;
		if (host_wr_i && (host_addr_i < `SV_ADDR_PAL_BASE)) begin
			case (host_addr_i)
				`SV_ADDR_HSCRL_LO: sel = SEL_HSCRL_LO;
				`SV_ADDR_HSCRL_HI: sel = SEL_HSCRL_HI;
				`SV_ADDR_VSCRL:    sel = SEL_VSCRL;
				default:           sel = SEL_NONE;
			endcase
		end
	end

	assign scroll_wr = (sel != SEL_NONE);

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			h_scroll_o <= '0;
			v_scroll_o <= '0;
		end else begin
			case (sel)
				SEL_HSCRL_LO: h_scroll_o[7:0] <= host_data_i[7:0];
				SEL_HSCRL_HI: h_scroll_o[8]   <= host_data_i[0]; // one bit latch
				SEL_VSCRL:    v_scroll_o      <= host_data_i[`SV_VPOS_W-1:0];
				default:      ;
			endcase
		end
	end

	// upper half is palette, written on the next edge
	assign pal_we_o   = host_wr_i && (host_addr_i >= `SV_ADDR_PAL_BASE);
	assign pal_idx_o  = host_addr_i[`SV_COLOR_W-1:0];
	assign pal_data_o = host_data_i;

	a_wr_exclusive: assert property (
		@(posedge pixel_clk) disable iff (!RESET_n) !(scroll_wr && pal_we_o)
	);

endmodule

`default_nettype wire

//--- design/scroll_position.sv
`timescale 1ns/1ps
`default_nettype none

`include "slapfight_video_macros.svh"

module scroll_position (
	input  wire                   pixel_clk,
	input  wire                   RESET_n,
	raster_if.scroll_mp           raster,
	input  wire [`SV_HPOS_W-1:0]  h_scroll_i,
	input  wire [`SV_VPOS_W-1:0]  v_scroll_i,
	output logic [`SV_HPOS_W-1:0] bg_h_o,
	output logic [`SV_VPOS_W-1:0] bg_v_o
);

	localparam logic [`SV_HPOS_W-1:0] H_LAST = `SV_H_TOTAL - 1;

	logic [`SV_HPOS_W-1:0] h_sum;
	logic [`SV_VPOS_W-1:0] v_sum;
	logic [`SV_HPOS_W-1:0] h_count; // raw count, flip undone

	// adders wrap naturally at 512 and 256
	assign h_sum = raster.h_pos + h_scroll_i;
	assign v_sum = raster.v_pos + v_scroll_i;

	// latch stage, one cycle behind the raster
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			bg_h_o <= '0;
			bg_v_o <= '0;
		end else begin
			bg_h_o <= h_sum;
			bg_v_o <= v_sum;
		end
	end

	// position steps by one per pixel, down when flipped
	assign h_count = raster.h_pos ^ {`SV_HPOS_W{raster.flip}};

	a_raster_step: assert property (
		@(posedge pixel_clk) disable iff (!RESET_n)
		(h_count != H_LAST) |=> (raster.h_pos == (raster.flip ?
			$past(raster.h_pos) - 1'b1 : $past(raster.h_pos) + 1'b1))
	);

endmodule

`default_nettype wire

//--- design/layer_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module layer_mixer import slapfight_video_pkg::*; (
	input  wire         pixel_clk,
	input  wire         RESET_n,
	raster_if.mix_mp    raster,
	input  color_code_u fg_code_i,
	input  color_code_u sp_code_i,
	input  color_code_u bg_code_i,
	output color_code_u mix_code_o,
	output logic        mix_blank_o
);

	color_code_u win_code;
	logic        fg_opaque;
	logic        sp_opaque;

	// fg pen is 2 bits, sprite pen is 4 bits of the same word
	assign fg_opaque = (fg_code_i.fg.pen != 2'd0);
	assign sp_opaque = (sp_code_i.sp.pen != 4'd0);

	// ============================================================
	// priority fg > sprite > bg
	// ============================================================
	always_comb begin
		if (fg_opaque)
			win_code = fg_code_i;
		else if (sp_opaque)
			win_code = sp_code_i;
		else
			win_code = bg_code_i; // bg always opaque
	end

	// colour register, blank rides along
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			mix_code_o  <= '0;
			mix_blank_o <= 1'b1;
		end else begin
			mix_code_o  <= win_code;
			mix_blank_o <= raster.h_blank | raster.v_blank;
		end
	end

endmodule

`default_nettype wire

//--- design/palette_lookup.sv
`timescale 1ns/1ps
`default_nettype none

`include "slapfight_video_macros.svh"

module palette_lookup import slapfight_video_pkg::*; (
	input  wire                    pixel_clk,
	input  wire                    RESET_n,
	input  wire                    pal_we_i,
	input  wire [`SV_COLOR_W-1:0]  pal_idx_i,
	input  rgb_t                   pal_data_i,
	input  color_code_u            code_i,
	input  wire                    blank_i,
	output rgb_t                   rgb_o
);

	localparam int PAL_DEPTH = 1 << `SV_COLOR_W; // 256 entries

	rgb_t pal_mem [0:PAL_DEPTH-1]; // replaces the three colour proms

	// host write port
	always_ff @(posedge pixel_clk) begin
		if (pal_we_i)
			pal_mem[pal_idx_i] <= pal_data_i;
	end

	// ============================================================
	// registered read, black while blanked
	// ============================================================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n)
			rgb_o <= '0;
		else if (blank_i)
			rgb_o <= '0; // no colour outside the window
		else
			rgb_o <= pal_mem[code_i];
	end

endmodule

`default_nettype wire

//--- design/slapfight_video.sv
`timescale 1ns/1ps
`default_nettype none

`include "slapfight_video_macros.svh"

module slapfight_video import slapfight_video_pkg::*; (
	input  wire                        pixel_clk,
	input  wire                        RESET_n,
	input  wire                        flip_i,
	input  wire                        host_wr_i,
	input  wire [`SV_HOST_ADDR_W-1:0]  host_addr_i,
	input  wire [`SV_HOST_DATA_W-1:0]  host_data_i,
	input  wire [`SV_COLOR_W-1:0]      fg_code_i,
	input  wire [`SV_COLOR_W-1:0]      sp_code_i,
	input  wire [`SV_COLOR_W-1:0]      bg_code_i,
	output logic [`SV_RGB_CH_W-1:0]    red_o,
	output logic [`SV_RGB_CH_W-1:0]    green_o,
	output logic [`SV_RGB_CH_W-1:0]    blue_o,
	output logic                       h_sync_o,
	output logic                       v_sync_o,
	output logic                       blank_o,
	output logic [`SV_HPOS_W-1:0]      bg_h_o,   // for an outside bg fetch
	output logic [`SV_VPOS_W-1:0]      bg_v_o
);

	logic [`SV_HPOS_W-1:0]  h_scroll;
	logic [`SV_VPOS_W-1:0]  v_scroll;
	logic                   pal_we;
	logic [`SV_COLOR_W-1:0] pal_idx;
	rgb_t                   pal_data;
	color_code_u            mix_code;
	logic                   mix_blank;
	rgb_t                   rgb;

	raster_if raster ();

	video_timing_gen u_timing (
		.pixel_clk (pixel_clk),
		.RESET_n   (RESET_n),
		.flip_i    (flip_i),
		.raster    (raster.timing_mp),
		.h_sync_o  (h_sync_o),
		.v_sync_o  (v_sync_o),
		.blank_o   (blank_o)
	);

	scroll_regs u_regs (
		.pixel_clk   (pixel_clk),
		.RESET_n     (RESET_n),
		.host_wr_i   (host_wr_i),
		.host_addr_i (host_addr_i),
		.host_data_i (host_data_i),
		.h_scroll_o  (h_scroll),
		.v_scroll_o  (v_scroll),
		.pal_we_o    (pal_we),
		.pal_idx_o   (pal_idx),
		.pal_data_o  (pal_data)
	);

	scroll_position u_scroll (
		.pixel_clk  (pixel_clk),
		.RESET_n    (RESET_n),
		.raster     (raster.scroll_mp),
		.h_scroll_i (h_scroll),
		.v_scroll_i (v_scroll),
		.bg_h_o     (bg_h_o),
		.bg_v_o     (bg_v_o)
	);

	layer_mixer u_mixer (
		.pixel_clk   (pixel_clk),
		.RESET_n     (RESET_n),
		.raster      (raster.mix_mp),
		.fg_code_i   (fg_code_i),
		.sp_code_i   (sp_code_i),
		.bg_code_i   (bg_code_i),
		.mix_code_o  (mix_code),
		.mix_blank_o (mix_blank)
	);

	palette_lookup u_palette (
		.pixel_clk  (pixel_clk),
		.RESET_n    (RESET_n),
		.pal_we_i   (pal_we),
		.pal_idx_i  (pal_idx),
		.pal_data_i (pal_data),
		.code_i     (mix_code),
		.blank_i    (mix_blank),
		.rgb_o      (rgb)
	);

	// split the palette word onto the dac pins
	assign red_o   = rgb.red;
	assign green_o = rgb.green;
	assign blue_o  = rgb.blue;

endmodule

`default_nettype wire

//--- verif/tb_slapfight_video.sv
`timescale 1ns/1ps
`default_nettype none

`include "slapfight_video_macros.svh"

module tb_slapfight_video import slapfight_video_pkg::*; ();

	localparam int CLK_PERIOD    = 100;
	localparam int DRIVE_DLY     = 10;  // inputs change this long after the edge
	localparam int RESET_CYCLES  = 4;
	localparam int FRAME_CYCLES  = `SV_H_TOTAL * `SV_V_TOTAL;
	localparam int FRAMES_TESTED = 2;   // one counted frame plus the shorter phases
	localparam int WATCHDOG_NS   = 2 * FRAME_CYCLES * FRAMES_TESTED * CLK_PERIOD;
	localparam int N_VEC         = 20;
	localparam int VEC_WORDS     = 8;   // words per line of the vector file
	localparam int SWEEP_CYCLES  = 768; // two lines, crosses the h blank twice
	localparam int FLIP_CYCLES   = 768;
	localparam int FIRST_LINE    = 20;  // a visible line for the file vectors
	localparam logic [31:0] SEED = 32'd1763;

	logic                        pixel_clk;
	logic                        RESET_n;
	logic                        flip_i;
	logic                        host_wr_i;
	logic [`SV_HOST_ADDR_W-1:0]  host_addr_i;
	logic [`SV_HOST_DATA_W-1:0]  host_data_i;
	logic [`SV_COLOR_W-1:0]      fg_code_i;
	logic [`SV_COLOR_W-1:0]      sp_code_i;
	logic [`SV_COLOR_W-1:0]      bg_code_i;
	logic [`SV_RGB_CH_W-1:0]     red_o;
	logic [`SV_RGB_CH_W-1:0]     green_o;
	logic [`SV_RGB_CH_W-1:0]     blue_o;
	logic                        h_sync_o;
	logic                        v_sync_o;
	logic                        blank_o;
	logic [`SV_HPOS_W-1:0]       bg_h_o;
	logic [`SV_VPOS_W-1:0]       bg_v_o;

	// reference state, rebuilt from the timing rules
	int                     cyc;     // edges since reset release
	logic                   flip_m;
	logic [`SV_HPOS_W-1:0]  hs_reg;  // scroll regs as they stand after the last edge
	logic [`SV_HPOS_W-1:0]  hs_next;
	logic [`SV_VPOS_W-1:0]  vs_reg;
	logic [`SV_VPOS_W-1:0]  vs_next;
	rgb_t                   pal_model [0:255];
	rgb_t                   rgb_q [$];  // expected colours in flight
	color_code_u            code_q [$]; // expected mixer word in flight
	logic [31:0]            lcg_state;
	logic [11:0]            vec_mem [0:N_VEC*VEC_WORDS-1];

	bit counting;
	int cnt_hs;
	int cnt_vs;
	int cnt_bl;
	int rgb_errs;
	int code_errs;
	int pos_errs;
	int flag_errs;
	int count_errs;

	slapfight_video UUT (
		.pixel_clk   (pixel_clk),
		.RESET_n     (RESET_n),
		.flip_i      (flip_i),
		.host_wr_i   (host_wr_i),
		.host_addr_i (host_addr_i),
		.host_data_i (host_data_i),
		.fg_code_i   (fg_code_i),
		.sp_code_i   (sp_code_i),
		.bg_code_i   (bg_code_i),
		.red_o       (red_o),
		.green_o     (green_o),
		.blue_o      (blue_o),
		.h_sync_o    (h_sync_o),
		.v_sync_o    (v_sync_o),
		.blank_o     (blank_o),
		.bg_h_o      (bg_h_o),
		.bg_v_o      (bg_v_o)
	);

	initial begin
		pixel_clk = 1'b0;
		forever #(CLK_PERIOD / 2) pixel_clk = ~pixel_clk;
	end

	// ============================================================
	// raster model from the cycle count
	// ============================================================
	function automatic int h_count_at(input int k);
		h_count_at = k % `SV_H_TOTAL;
	endfunction

	function automatic int v_count_at(input int k);
		v_count_at = (k / `SV_H_TOTAL) % `SV_V_TOTAL;
	endfunction

	function automatic logic blank_at(input int k);
		int v;
		v = v_count_at(k);
		blank_at = (h_count_at(k) >= `SV_H_ACTIVE) || (v < `SV_V_ACTIVE_START) ||
			(v >= `SV_V_ACTIVE_END);
	endfunction

	function automatic logic hsync_at(input int k);
		hsync_at = (h_count_at(k) >= `SV_H_SYNC_START) && (h_count_at(k) < `SV_H_SYNC_END);
	endfunction

	function automatic logic vsync_at(input int k);
		vsync_at = (v_count_at(k) >= `SV_V_SYNC_START) && (v_count_at(k) < `SV_V_SYNC_END);
	endfunction

	function automatic logic [`SV_HPOS_W-1:0] raster_h(input int k);
		logic [`SV_HPOS_W-1:0] h;
		h = `SV_HPOS_W'(h_count_at(k));
		raster_h = flip_m ? ~h : h; // flipped screen runs backwards
	endfunction

	function automatic logic [`SV_VPOS_W-1:0] raster_v(input int k);
		logic [`SV_VPOS_W-1:0] v;
		v = `SV_VPOS_W'(v_count_at(k));
		raster_v = flip_m ? ~v : v;
	endfunction

	// fg pen nonzero wins, then sprite pen, then bg
	function automatic color_code_u pick_layer(input color_code_u fg, input color_code_u sp,
		input color_code_u bg);
		if (fg.fg.pen != 2'd0)
			pick_layer = fg;
		else if (sp.sp.pen != 4'd0)
			pick_layer = sp;
		else
			pick_layer = bg;
	endfunction

	// every address bit shows up in the entry
	function automatic rgb_t pal_fill(input logic [7:0] idx);
		pal_fill = {idx[7:4], idx[3:0] ^ 4'h5, idx[7:4] ^ idx[3:0]};
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		lcg_next = s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic next_rand(output logic [7:0] b);
		lcg_state = lcg_next(lcg_state);
		b = lcg_state[23:16]; // upper bits, the low ones cycle fast
	endtask

	// ============================================================
	// compare tasks
	// ============================================================
	task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
		if (got !== exp) begin
			rgb_errs++;
			$display("FAILED %s got %h expected %h at cycle %0d", name, got, exp, cyc);
		end
	endtask

	task automatic check_code(input string name, input color_code_u got,
		input color_code_u exp);
		if (got !== exp) begin
			code_errs++;
			$display("FAILED %s got %h expected %h at cycle %0d", name, got, exp, cyc);
		end
	endtask

	task automatic check_pos(input string name, input logic [`SV_HPOS_W-1:0] got,
		input logic [`SV_HPOS_W-1:0] exp);
		if (got !== exp) begin
			pos_errs++;
			$display("FAILED %s got %h expected %h at cycle %0d", name, got, exp, cyc);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			flag_errs++;
			$display("FAILED %s got %h expected %h at cycle %0d", name, got, exp, cyc);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			count_errs++;
			$display("FAILED %s count got %h expected %h", name, got, exp);
		end
	endtask

	// ============================================================
	// cycle driver and checker
	// ============================================================
	task automatic drive_cycle(input logic wr, input logic [`SV_HOST_ADDR_W-1:0] addr,
		input logic [`SV_HOST_DATA_W-1:0] data, input color_code_u fg,
		input color_code_u sp, input color_code_u bg, input logic use_file,
		input rgb_t file_rgb);
		color_code_u win;
		rgb_t        exp;
		host_wr_i   = wr;
		host_addr_i = addr;
		host_data_i = data;
		fg_code_i   = fg;
		sp_code_i   = sp;
		bg_code_i   = bg;
		hs_next     = hs_reg;
		vs_next     = vs_reg;
		if (wr) begin
			if (addr >= `SV_ADDR_PAL_BASE)
				pal_model[addr[7:0]] = rgb_t'(data); // visible to this cycle's codes
			else if (addr == `SV_ADDR_HSCRL_LO)
				hs_next[7:0] = data[7:0];
			else if (addr == `SV_ADDR_HSCRL_HI)
				hs_next[8] = data[0];
			else if (addr == `SV_ADDR_VSCRL)
				vs_next = data[7:0];
		end
		win = pick_layer(fg, sp, bg);
		if (blank_at(cyc))
			exp = '0;
		else
			exp = pal_model[win];
		code_q.push_back(win);
		rgb_q.push_back(use_file ? file_rgb : exp);
	endtask

	task automatic idle_cycle();
		drive_cycle(1'b0, '0, '0, '0, '0, '0, 1'b0, '0);
	endtask

	task automatic step_cycle();
		rgb_t                  dut_rgb;
		color_code_u           exp_code;
		rgb_t                  exp_rgb;
		logic [`SV_HPOS_W-1:0] exp_h;
		logic [`SV_VPOS_W-1:0] exp_v;
		@(posedge pixel_clk);
		#(DRIVE_DLY);
		cyc++;
		// bg position is one cycle behind the raster
		exp_h = raster_h(cyc - 1) + hs_reg;
		exp_v = raster_v(cyc - 1) + vs_reg;
		check_pos("bg_h_o", bg_h_o, exp_h);
		check_pos("bg_v_o", {1'b0, bg_v_o}, {1'b0, exp_v});
		hs_reg = hs_next;
		vs_reg = vs_next;
		if (cyc >= `SV_PIPE_LAT) begin
			check_flag("h_sync_o", h_sync_o, hsync_at(cyc - `SV_PIPE_LAT));
			check_flag("v_sync_o", v_sync_o, vsync_at(cyc - `SV_PIPE_LAT));
			check_flag("blank_o", blank_o, blank_at(cyc - `SV_PIPE_LAT));
		end else begin
			check_flag("h_sync_o", h_sync_o, 1'b0); // still reset values
			check_flag("v_sync_o", v_sync_o, 1'b0);
			check_flag("blank_o", blank_o, 1'b1);
		end
		if (counting) begin
			cnt_hs += h_sync_o;
			cnt_vs += v_sync_o;
			cnt_bl += blank_o;
		end
		if (code_q.size() == 1) begin
			exp_code = code_q.pop_front();
			check_code("mix_code_o", UUT.u_mixer.mix_code_o, exp_code);
		end
		if (rgb_q.size() == `SV_PIPE_LAT) begin
			exp_rgb = rgb_q.pop_front();
			dut_rgb = {red_o, green_o, blue_o};
			check_rgb("rgb_o", dut_rgb, exp_rgb);
		end
	endtask

	task automatic apply_reset(input logic flip);
		RESET_n = 1'b0;
		flip_i  = flip;
		idle_cycle();
		repeat (RESET_CYCLES) @(posedge pixel_clk);
		#(DRIVE_DLY);
		RESET_n = 1'b1;
		flip_i  = ~flip; // screen keeps the value taken during reset
		cyc     = 0;
		flip_m  = flip;
		hs_reg  = '0;
		hs_next = '0;
		vs_reg  = '0;
		vs_next = '0;
		rgb_q.delete();
		code_q.delete();
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("ERROR: watchdog expired before the tests finished");
		$display("test failed");
		$finish;
	end

	// ============================================================
	// main sequence
	// ============================================================
	initial begin
		int          i;
		int          base;
		logic [7:0]  r0;
		logic [7:0]  r1;
		logic [7:0]  r2;
		int          total;
		RESET_n     = 1'b0;
		flip_i      = 1'b0;
		host_wr_i   = 1'b0;
		host_addr_i = '0;
		host_data_i = '0;
		fg_code_i   = '0;
		sp_code_i   = '0;
		bg_code_i   = '0;
		counting    = 1'b0;
		cnt_hs      = 0;
		cnt_vs      = 0;
		cnt_bl      = 0;
		rgb_errs    = 0;
		code_errs   = 0;
		pos_errs    = 0;
		flag_errs   = 0;
		count_errs  = 0;
		lcg_state   = SEED;
		$readmemh("verif/video_input.txt", vec_mem);
		apply_reset(1'b0);

		// whole palette, line 0 is blanked anyway
		for (i = 0; i < 256; i++) begin
			drive_cycle(1'b1, `SV_HOST_ADDR_W'(`SV_ADDR_PAL_BASE + i),
				12'(pal_fill(8'(i))), '0, '0, '0, 1'b0, '0);
			step_cycle();
		end

		// one full frame of sync and blank
		counting = 1'b1;
		repeat (FRAME_CYCLES) begin
			idle_cycle();
			step_cycle();
		end
		counting = 1'b0;
		check_count("h_sync_o", cnt_hs,
			(`SV_H_SYNC_END - `SV_H_SYNC_START) * `SV_V_TOTAL);
		check_count("v_sync_o", cnt_vs,
			(`SV_V_SYNC_END - `SV_V_SYNC_START) * `SV_H_TOTAL);
		check_count("blank_o", cnt_bl, FRAME_CYCLES -
			`SV_H_ACTIVE * (`SV_V_ACTIVE_END - `SV_V_ACTIVE_START));

		// file vectors start at column 0 of a visible line
		while (!(h_count_at(cyc) == 0 && v_count_at(cyc) == FIRST_LINE)) begin
			idle_cycle();
			step_cycle();
		end
		for (i = 0; i < N_VEC; i++) begin
			base = i * VEC_WORDS;
			drive_cycle(vec_mem[base][0], vec_mem[base+1][8:0], vec_mem[base+2],
				vec_mem[base+3][7:0], vec_mem[base+4][7:0], vec_mem[base+5][7:0],
				vec_mem[base+7][0], rgb_t'(vec_mem[base+6]));
			step_cycle();
		end

		// random priority sweep, runs through h blank too
		repeat (SWEEP_CYCLES) begin
			next_rand(r0);
			next_rand(r1);
			next_rand(r2);
			drive_cycle(1'b0, '0, '0, r0, r1, r2, 1'b0, '0);
			step_cycle();
		end

		// flipped screen, scroll back to zero by reset
		apply_reset(1'b1);
		idle_cycle();
		step_cycle();
		check_pos("bg_h_o", bg_h_o, 9'h1ff); // first flipped column
		repeat (FLIP_CYCLES) begin
			idle_cycle();
			step_cycle();
		end

		total = rgb_errs + code_errs + pos_errs + flag_errs + count_errs;
		$display("errors: rgb %0d, code %0d, pos %0d, flag %0d, count %0d",
			rgb_errs, code_errs, pos_errs, flag_errs, count_errs);
		if (total == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/video_input.txt
// wr addr data fg sp bg exp_rgb chk, all hex, one cycle per line
// exp_rgb is rgb_o two edges later, compared only where chk is 1
1 000 034 00 00 00 000 0
1 001 001 00 00 00 000 0
1 002 05a 00 00 00 000 0
1 105 f00 00 00 00 000 0
1 112 0f0 00 00 00 000 0
1 1a0 00f 00 00 00 000 0
1 137 abc 00 00 00 000 0
0 000 000 05 12 a0 f00 1
0 000 000 04 12 a0 0f0 1
0 000 000 04 10 a0 00f 1
0 000 000 37 12 a0 abc 1
0 000 000 00 a0 05 f00 1
0 000 000 a0 12 05 0f0 1
0 000 000 05 00 00 f00 1
1 105 123 00 00 a0 00f 1
0 000 000 05 00 00 123 1
0 000 000 00 00 37 abc 1
1 0c0 fff 37 00 00 abc 1
0 000 000 12 00 00 0f0 1
1 002 000 05 00 00 123 1

//--- project.f
+incdir+design
design/slapfight_video_pkg.sv
design/raster_if.sv
design/video_timing_gen.sv
design/scroll_regs.sv
design/scroll_position.sv
design/layer_mixer.sv
design/palette_lookup.sv
design/slapfight_video.sv
verif/tb_slapfight_video.sv

//--- run_sim.sh
#!/bin/sh
# build and run the slapfight video testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module tb_slapfight_video -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/Vtb_slapfight_video > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "test failed" "$LOG"; then
	exit 1
fi
if ! grep -q "test passed" "$LOG"; then
	echo "no result line found in $LOG"
	exit 1
fi
exit 0
